//--- build.f
simon_pkg.sv
color_lfsr.sv
step_timer.sv
button_encoder.sv
simon_controller.sv
simon_top.sv
tb_simon.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then judge the log
verilator --binary --timing --assert -f build.f --top-module tb_simon -o sim_simon \
    && ./obj_dir/sim_simon > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } \
    || echo "Simulation finished without failure"

//--- tb_simon.sv
`timescale 1ns/1ps

module tb_simon import simon_pkg::*; ();

    localparam int PRESS_CYCLES   = 4;
    localparam int RELEASE_CYCLES = 4;
    localparam int LONG_HOLD      = 20;
    localparam int MAX_LOSE_ROUND = 7;
    localparam int END_WAIT       = 30;
    // One display cycle plus the timer run
    localparam int LAMP_ON_CYCLES = STEP_TICKS + 1;
    // Each shown step costs one lamp interval, one gap and one press
    localparam int STEP_COST  = LAMP_ON_CYCLES + 1 + PRESS_CYCLES + RELEASE_CYCLES;
    localparam int WIN_STEPS  = MAX_TURNS * (MAX_TURNS - 1) / 2;
    localparam int LOSE_STEPS = (MAX_LOSE_ROUND + 1) * (MAX_LOSE_ROUND + 2) / 2;
    localparam int MAX_CYCLES = 2 * STEP_COST * (WIN_STEPS + 3 * LOSE_STEPS) + 1000;

    logic               CLK = 1'b0;
    logic               RST_N;
    logic [3:0]         buttons;
    logic               start_game;
    logic [COLOR_W-1:0] lamp_color;
    logic               lamp_on;
    logic               win;
    logic               lose;
    logic               new_best;
    logic [SCORE_W-1:0] best_score;
    logic [SCORE_W-1:0] score;

    // Written by the player process
    int          round_mark;
    int          cur_round;
    int          step_base;
    bit          lamp_allowed;
    int          game_base;
    int          max_score;
    int          game_err = 0;
    logic [31:0] rng_state;

    // Written by the checker process
    int   seen_steps = 0;
    int   win_cnt    = 0;
    int   lose_cnt   = 0;
    int   best_cnt   = 0;
    int   chk_err    = 0;
    int   on_len     = 0;
    int   gap_len    = 0;
    int   rel        = 0;
    logic lamp_prev  = 1'b0;
    int   cycle_cnt  = 0;

    simon_top UUT (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .buttons    (buttons),
        .start_game (start_game),
        .lamp_color (lamp_color),
        .lamp_on    (lamp_on),
        .win        (win),
        .lose       (lose),
        .new_best   (new_best),
        .best_score (best_score),
        .score      (score)
    );

    always #10 CLK = ~CLK;

    // k-th colour of the Galois LFSR stream since reset
    function automatic logic [COLOR_W-1:0] ref_color(input int k);
        logic [LFSR_W-1:0] s;
        s = LFSR_SEED;
        for (int j = 0; j < k; j++) begin
            s = (s >> 1) ^ (s[0] ? LFSR_TAPS : '0);
        end
        return s[COLOR_W-1:0];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Playback and pulse checker, samples registered outputs at the rising edge
    always @(posedge CLK) begin
        if (RST_N) begin
            if (lamp_on && !lamp_prev) begin
                rel = seen_steps - round_mark;
                assert (lamp_allowed && rel <= cur_round) else begin
                    chk_err++;
                    $display("[ERROR] %0t: unexpected lamp step %0d in round %0d",
                             $time, rel, cur_round);
                end
                assert (lamp_color == ref_color(step_base + rel)) else begin
                    chk_err++;
                    $display("[ERROR] %0t: lamp colour %0d at step %0d, expected %0d",
                             $time, lamp_color, rel, ref_color(step_base + rel));
                end
                if (rel != 0) begin
                    assert (gap_len == 1) else begin
                        chk_err++;
                        $display("[ERROR] %0t: lamp gap of %0d cycles, expected 1",
                                 $time, gap_len);
                    end
                end
                seen_steps = seen_steps + 1;
                on_len = 0;
            end
            if (!lamp_on && lamp_prev) begin
                assert (on_len == LAMP_ON_CYCLES) else begin
                    chk_err++;
                    $display("[ERROR] %0t: lamp on for %0d cycles, expected %0d",
                             $time, on_len, LAMP_ON_CYCLES);
                end
                gap_len = 0;
            end
            if (lamp_on) begin
                on_len = on_len + 1;
            end else begin
                gap_len = gap_len + 1;
            end
            if (win) begin
                win_cnt = win_cnt + 1;
            end
            if (lose) begin
                lose_cnt = lose_cnt + 1;
            end
            if (new_best) begin
                best_cnt = best_cnt + 1;
                assert (win || lose) else begin
                    chk_err++;
                    $display("[ERROR] %0t: new_best without a game end pulse", $time);
                end
            end
            lamp_prev = lamp_on;
        end
    end

    task automatic press_button(input logic [3:0] pattern, input int hold);
        buttons = pattern;
        repeat (hold) @(negedge CLK);
        buttons = 4'b0000;
        repeat (RELEASE_CYCLES) @(negedge CLK);
    endtask

    // Wait until all n+1 steps of round n are shown and the lamp is off
    task automatic wait_display(input int n);
        int waited;
        int limit;
        waited = 0;
        limit  = (n + 1) * (LAMP_ON_CYCLES + 1) + 20;
        while (!((seen_steps - round_mark == n + 1) && !lamp_on) && waited < limit) begin
            @(negedge CLK);
            waited++;
        end
        if (!((seen_steps - round_mark == n + 1) && !lamp_on)) begin
            game_err++;
            $display("Playback of round %0d did not finish within %0d cycles", n, limit);
        end
    endtask

    task automatic wait_game_end(input int wins0, input int loses0);
        int waited;
        waited = 0;
        while (win_cnt == wins0 && lose_cnt == loses0 && waited < END_WAIT) begin
            @(negedge CLK);
            waited++;
        end
        if (win_cnt == wins0 && lose_cnt == loses0) begin
            game_err++;
            $display("Game did not end with a win or lose pulse within %0d cycles", END_WAIT);
        end
        // Room for a stray second pulse or a lamp that should stay dark
        repeat (10) @(negedge CLK);
    endtask

    // A negative lose_round plays a full correct game
    task automatic play_game(input int lose_round, input int wrong_pos, input bit filter_test);
        int                 n;
        int                 i;
        int                 presses;
        int                 last_round;
        int                 exp_score;
        int                 wins0;
        int                 loses0;
        int                 bests0;
        bit                 exp_new_best;
        logic [COLOR_W-1:0] c;
        last_round   = (lose_round < 0) ? MAX_TURNS - 2 : lose_round;
        exp_score    = (lose_round < 0) ? MAX_TURNS - 1 : lose_round;
        wins0        = win_cnt;
        loses0       = lose_cnt;
        bests0       = best_cnt;
        round_mark   = seen_steps;
        cur_round    = 0;
        step_base    = game_base;
        lamp_allowed = 1'b1;
        start_game   = 1'b1;
        @(negedge CLK);
        start_game = 1'b0;
        for (n = 0; n <= last_round; n++) begin
            wait_display(n);
            presses = (n == lose_round) ? wrong_pos : n + 1;
            for (i = 0; i < presses; i++) begin
                if (filter_test && n == 1 && i == 0) begin
                    // Chord first, then a long hold that counts once
                    press_button(4'b0101, PRESS_CYCLES);
                    press_button(4'b0001 << ref_color(game_base + i), LONG_HOLD);
                end else begin
                    if (i == n) begin
                        // Next playback may start before this press returns
                        round_mark = round_mark + n + 1;
                        cur_round  = n + 1;
                    end
                    press_button(4'b0001 << ref_color(game_base + i), PRESS_CYCLES);
                end
            end
            if (n == lose_round) begin
                c = ref_color(game_base + wrong_pos) + 1'b1;
                press_button(4'b0001 << c, PRESS_CYCLES);
            end
        end
        lamp_allowed = 1'b0;
        wait_game_end(wins0, loses0);

        exp_new_best = (exp_score > max_score);
        assert (win_cnt - wins0 == ((lose_round < 0) ? 1 : 0) &&
                lose_cnt - loses0 == ((lose_round < 0) ? 0 : 1)) else begin
            game_err++;
            $display("[ERROR] %0t: %0d win and %0d lose pulses, expected a %s",
                     $time, win_cnt - wins0, lose_cnt - loses0,
                     (lose_round < 0) ? "win" : "loss");
        end
        assert (score == SCORE_W'(exp_score)) else begin
            game_err++;
            $display("[ERROR] %0t: score %0d, expected %0d", $time, score, exp_score);
        end
        assert (best_cnt - bests0 == (exp_new_best ? 1 : 0)) else begin
            game_err++;
            $display("[ERROR] %0t: %0d new_best pulses, expected %0d",
                     $time, best_cnt - bests0, exp_new_best);
        end
        if (exp_new_best) begin
            max_score = exp_score;
        end
        assert (best_score == SCORE_W'(max_score)) else begin
            game_err++;
            $display("[ERROR] %0t: best_score %0d, expected %0d", $time, best_score, max_score);
        end
        game_base = game_base + last_round + 1;
    endtask

    task automatic check_reset_state();
        assert (!lamp_on && !win && !lose && !new_best) else begin
            game_err++;
            $display("[ERROR] %0t: status outputs not low after reset", $time);
        end
        assert (lamp_color == COLOR_W'(3)) else begin
            game_err++;
            $display("[ERROR] %0t: lamp_color %0d after reset, expected 3", $time, lamp_color);
        end
        assert (score == '0 && best_score == '0) else begin
            game_err++;
            $display("[ERROR] %0t: score %0d and best_score %0d after reset, expected 0",
                     $time, score, best_score);
        end
    endtask

    initial begin
        int g;
        int lose_round;
        int wrong_pos;
        RST_N        = 1'b0;
        buttons      = 4'b0000;
        start_game   = 1'b0;
        round_mark   = 0;
        cur_round    = 0;
        step_base    = 0;
        lamp_allowed = 1'b0;
        game_base    = 0;
        max_score    = 0;
        rng_state    = 32'h5e12_ca43;
        repeat (5) @(negedge CLK);
        RST_N = 1'b1;
        repeat (3) @(negedge CLK);
        check_reset_state();

        // Three lost games with random length, then a full win
        for (g = 0; g < 3; g++) begin
            rng_state  = xorshift32(rng_state);
            lose_round = int'(rng_state % 32'(MAX_LOSE_ROUND + 1));
            rng_state  = xorshift32(rng_state);
            wrong_pos  = int'(rng_state % 32'(lose_round + 1));
            play_game(lose_round, wrong_pos, 1'b0);
        end
        play_game(-1, 0, 1'b1);

        repeat (10) @(negedge CLK);
        $display("Error counts: playback %0d, game %0d", chk_err, game_err);
        if (chk_err + game_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge CLK);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Error counts: playback %0d, game %0d", chk_err, game_err);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : tb_simon

//--- simon_top.sv
`timescale 1ns/1ps

module simon_top import simon_pkg::*; (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic [3:0]         buttons,
    input  logic               start_game,
    output logic [COLOR_W-1:0] lamp_color,
    output logic               lamp_on,
    output logic               win,
    output logic               lose,
    output logic               new_best,
    output logic [SCORE_W-1:0] best_score,
    output logic [SCORE_W-1:0] score
);

    logic [COLOR_W-1:0] press_color;
    logic               press_valid;
    logic [COLOR_W-1:0] rand_color;
    logic               color_take;
    logic               timer_go;
    logic               timer_pulse;

    button_encoder u_button_encoder (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .buttons     (buttons),
        .press_color (press_color),
        .press_valid (press_valid)
    );

    color_lfsr u_color_lfsr (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .color_take (color_take),
        .rand_color (rand_color)
    );

    step_timer u_step_timer (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .timer_go    (timer_go),
        .timer_pulse (timer_pulse)
    );

    simon_controller u_simon_controller (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .start_game  (start_game),
        .press_color (press_color),
        .press_valid (press_valid),
        .rand_color  (rand_color),
        .timer_pulse (timer_pulse),
        .color_take  (color_take),
        .timer_go    (timer_go),
        .lamp_color  (lamp_color),
        .lamp_on     (lamp_on),
        .win         (win),
        .lose        (lose),
        .new_best    (new_best),
        .score       (score),
        .best_score  (best_score)
    );

endmodule : simon_top

//--- simon_controller.sv
`timescale 1ns/1ps

module simon_controller import simon_pkg::*; (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               start_game,
    input  logic [COLOR_W-1:0] press_color,
    input  logic               press_valid,
    input  logic [COLOR_W-1:0] rand_color,
    input  logic               timer_pulse,
    output logic               color_take,
    output logic               timer_go,
    output logic [COLOR_W-1:0] lamp_color,
    output logic               lamp_on,
    output logic               win,
    output logic               lose,
    output logic               new_best,
    output logic [SCORE_W-1:0] score,
    output logic [SCORE_W-1:0] best_score
);

    ctrl_state_e state;

    // Entry being shown or checked
    logic [TURN_W-1:0] step_idx;
    // Colours held in the store this game
    logic [TURN_W-1:0] round_cnt;
    // Game ended by a full store
    logic              won;
    logic              store_full;
    logic              store_wr;

    logic [COLOR_W-1:0] store [MAX_TURNS];

    assign store_full = (round_cnt == TURN_W'(MAX_TURNS - 1));
    assign store_wr   = (state == CTRL_ADD_COLOR_S) && !store_full;

    // Colour store
    always_ff @(posedge CLK) begin
        if (store_wr) begin
            store[round_cnt] <= rand_color;
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state      <= CTRL_IDLE_S;
            step_idx   <= '0;
            round_cnt  <= '0;
            won        <= 1'b0;
            color_take <= 1'b0;
            timer_go   <= 1'b0;
            lamp_color <= COLOR_W'(3);
            lamp_on    <= 1'b0;
            win        <= 1'b0;
            lose       <= 1'b0;
            new_best   <= 1'b0;
            score      <= '0;
            best_score <= '0;
        end else begin
            // Pulses drop back by default
            color_take <= 1'b0;
            timer_go   <= 1'b0;
            win        <= 1'b0;
            lose       <= 1'b0;
            new_best   <= 1'b0;

            unique case (state)
                CTRL_IDLE_S: begin
                    step_idx  <= '0;
                    round_cnt <= '0;
                    if (start_game) begin
                        score <= '0;
                        won   <= 1'b0;
                        state <= CTRL_ADD_COLOR_S;
                    end
                end

                CTRL_ADD_COLOR_S: begin
                    if (store_full) begin
                        state <= CTRL_WIN_S;
                    end else begin
                        // Store write happens in the store block
                        color_take <= 1'b1;
                        state      <= CTRL_DISPLAY_S;
                    end
                end

                CTRL_DISPLAY_S: begin
                    lamp_on    <= 1'b1;
                    lamp_color <= store[step_idx];
                    timer_go   <= 1'b1;
                    state      <= CTRL_DISPLAY2_S;
                end

                CTRL_DISPLAY2_S: begin
                    if (timer_pulse) begin
                        lamp_on <= 1'b0;
                        if (step_idx == round_cnt) begin
                            // Whole sequence shown, hand over to the player
                            step_idx  <= '0;
                            round_cnt <= round_cnt + 1'b1;
                            state     <= CTRL_INPUT_S;
                        end else begin
                            step_idx <= step_idx + 1'b1;
                            state    <= CTRL_DISPLAY_S;
                        end
                    end
                end

                CTRL_INPUT_S: begin
                    if (press_valid) begin
                        if (press_color == store[step_idx]) begin
                            if (step_idx == round_cnt - 1'b1) begin
                                step_idx <= '0;
                                score    <= score + 1'b1;
                                state    <= CTRL_ADD_COLOR_S;
                            end else begin
                                step_idx <= step_idx + 1'b1;
                            end
                        end else begin
                            won   <= 1'b0;
                            state <= CTRL_END_S;
                        end
                    end
                end

                CTRL_WIN_S: begin
                    won   <= 1'b1;
                    state <= CTRL_END_S;
                end

                CTRL_END_S: begin
                    win  <= won;
                    lose <= !won;
                    // Best score kept across games
                    if (score > best_score) begin
                        best_score <= score;
                        new_best   <= 1'b1;
                    end
                    state <= CTRL_IDLE_S;
                end

                default: begin
                    state <= CTRL_IDLE_S;
                end
            endcase
        end
    end

    a_state_legal : assert property (@(posedge CLK) disable iff (!RST_N)
        state inside {CTRL_IDLE_S, CTRL_ADD_COLOR_S, CTRL_DISPLAY_S, CTRL_DISPLAY2_S,
                      CTRL_INPUT_S, CTRL_WIN_S, CTRL_END_S})
        else $error("simon_controller in illegal state %0d", state);

    a_win_lose_excl : assert property (@(posedge CLK) disable iff (!RST_N)
        !(win && lose))
        else $error("simon_controller raised win and lose together");

endmodule : simon_controller

//--- button_encoder.sv
`timescale 1ns/1ps

module button_encoder import simon_pkg::*; (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic [3:0]         buttons,
    output logic [COLOR_W-1:0] press_color,
    output logic               press_valid
);

    logic [3:0]         sync_meta;
    logic [3:0]         sync_btn;
    logic [3:0]         prev_btn;
    logic [3:0]         new_press;
    logic               accept;
    logic [COLOR_W-1:0] btn_code;

    // Two-flop synchroniser plus a delayed copy for edge detection
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            sync_meta <= '0;
            sync_btn  <= '0;
            prev_btn  <= '0;
        end else begin
            sync_meta <= buttons;
            sync_btn  <= sync_meta;
            prev_btn  <= sync_btn;
        end
    end

    assign new_press = sync_btn & ~prev_btn;

    // Only a lone button counts, anything chorded is dropped
    assign accept = $onehot(sync_btn) && (new_press != '0);

    always_comb begin
        unique case (sync_btn)
            4'b0010: btn_code = COLOR_W'(1);
            4'b0100: btn_code = COLOR_W'(2);
            4'b1000: btn_code = COLOR_W'(3);
            default: btn_code = COLOR_W'(0);
        endcase
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            press_valid <= 1'b0;
        end else begin
            press_valid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            press_color <= btn_code;
        end
    end

endmodule : button_encoder

//--- step_timer.sv
`timescale 1ns/1ps

module step_timer import simon_pkg::*; (
    input  logic CLK,
    input  logic RST_N,
    input  logic timer_go,
    output logic timer_pulse
);

    logic [TIMER_W-1:0] count;

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            count       <= '0;
            timer_pulse <= 1'b0;
        end else begin
            timer_pulse <= 1'b0;
            if (timer_go) begin
                // Restart also when a step is already running
                count <= TIMER_W'(STEP_TICKS);
            end else if (count != '0) begin
                count <= count - 1'b1;
                // Count reaches one on this edge, pulse goes out with it
                if (count == TIMER_W'(2)) begin
                    timer_pulse <= 1'b1;
                end
            end
        end
    end

    // One pulse per go, never a stretched pulse
    a_pulse_single : assert property (@(posedge CLK) disable iff (!RST_N)
        timer_pulse |=> !timer_pulse)
        else $error("step_timer pulse held for two cycles");

endmodule : step_timer

//--- color_lfsr.sv
`timescale 1ns/1ps

module color_lfsr import simon_pkg::*; (
    input  logic               CLK,
    input  logic               RST_N,
    input  logic               color_take,
    output logic [COLOR_W-1:0] rand_color
);

    logic [LFSR_W-1:0] lfsr_q;
    logic [LFSR_W-1:0] lfsr_next;

    // Shift right and fold the feedback mask in when a one drops out
    assign lfsr_next = {1'b0, lfsr_q[LFSR_W-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            lfsr_q <= LFSR_SEED;
        end else if (color_take) begin
            lfsr_q <= lfsr_next;
        end
    end

    // Low bits give the colour on offer
    assign rand_color = lfsr_q[COLOR_W-1:0];

    // A zero state would lock the source on one colour forever
    a_lfsr_nonzero : assert property (@(posedge CLK) disable iff (!RST_N)
        lfsr_q != '0)
        else $error("color_lfsr reached the all-zero state");

endmodule : color_lfsr

//--- simon_pkg.sv
package simon_pkg;

    // Colour code and sequence store
    localparam int COLOR_W   = 2;
    localparam int MAX_TURNS = 32;
    localparam int TURN_W    = 5;

    // Completed rounds fit up to MAX_TURNS
    localparam int SCORE_W   = 6;

    // Lamp step pacing
    localparam int STEP_TICKS = 4;
    localparam int TIMER_W    = 3;

    // Galois LFSR for the colour source
    localparam int              LFSR_W    = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;
    localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

    // Controller state encoding
    typedef enum logic [2:0] {
        CTRL_IDLE_S      = 3'd0,
        CTRL_ADD_COLOR_S = 3'd1,
        CTRL_DISPLAY_S   = 3'd2,
        CTRL_DISPLAY2_S  = 3'd3,
        CTRL_INPUT_S     = 3'd4,
        CTRL_WIN_S       = 3'd5,
        CTRL_END_S       = 3'd6
    } ctrl_state_e;

endpackage : simon_pkg
